// File: filelist.f
design/cmd_proc_pkg.sv
design/heading_error.sv
design/square_counter.sv
design/speed_ramp.sv
design/cmd_sequencer.sv
design/cmd_proc.sv
dv/tb_cmd_proc.sv

// File: Bender.yml
package:
  name: cmd_proc

sources:
  - files:
      - design/cmd_proc_pkg.sv
      - design/heading_error.sv
      - design/square_counter.sv
      - design/speed_ramp.sv
      - design/cmd_sequencer.sv
      - design/cmd_proc.sv
  - target: simulation
    files:
      - dv/tb_cmd_proc.sv

// File: dv/tb_cmd_proc.sv
////////////////////////////////////////////////////////////
// Directed testbench for the knight command processor.
// Runs calibration, tour, heading error, alignment and ramp,
// and move completion tests against the top level and
// stops at the first mismatch.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_cmd_proc
  import cmd_proc_pkg::*;
();

  localparam int PERIOD = 4;  // Clock period in ns.
  // Worst case cycles per phase of the run.
  localparam int BUDGET = 10 + 60 + 20 + 200 + 250 + 200;

  logic                        clk;
  logic                        rst_n;
  logic [CMD_W-1:0]            cmd;
  logic                        cmd_valid;
  logic                        cmd_ready;
  opcode_e                     resp_op;
  logic                        resp_valid;
  logic                        resp_ready;
  logic                        strt_cal;
  logic                        cal_done;
  logic signed [HEADING_W-1:0] heading;
  logic                        heading_rdy;
  logic                        lftIR;
  logic                        cntrIR;
  logic                        rghtIR;
  logic signed [HEADING_W-1:0] error;
  logic [SPEED_W-1:0]          frwrd;
  logic                        moving;
  logic                        tour_go;
  logic                        fanfare_go;

  int                 accept_cnt  = 0;  // Command transfers seen.
  int                 cal_cnt     = 0;  // strt_cal pulses.
  int                 tour_cnt    = 0;  // tour_go pulses.
  int                 fanfare_cnt = 0;  // fanfare_go pulses.
  logic [SPEED_W-1:0] exp_speed;        // Model of the forward speed.

  cmd_proc u_cmd_proc (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  // Pulses and transfers counted on the edge that sees them.
  always @(posedge clk) begin
    if (cmd_valid && cmd_ready) accept_cnt++;
    if (strt_cal)               cal_cnt++;
    if (tour_go)                tour_cnt++;
    if (fanfare_go)             fanfare_cnt++;
  end

  initial begin
    #(BUDGET * PERIOD);
    $display("Watchdog: the tests did not finish within %0d cycles.", BUDGET);
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped by the watchdog.");
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_error(input string name, input logic signed [HEADING_W-1:0] exp,
                             input logic signed [HEADING_W-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_speed(input string name, input logic [SPEED_W-1:0] exp,
                             input logic [SPEED_W-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected 'h%h got 'h%h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_op(input string name, input opcode_e exp, input opcode_e act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected 'h%h got 'h%h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_pulses(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("** Error at %0t ns: %s count expected %0d got %0d", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "Wrong count of %s.", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference rules and drivers
  ////////////////////////////////////////////////////////////
  function automatic logic signed [HEADING_W-1:0] desired_of(input logic [HFIELD_W-1:0] hf);
    if (hf == '0)
      return '0;                // Field of zero means north.
    return {hf, 4'b1111};
  endfunction

  function automatic logic signed [HEADING_W-1:0] expected_nudge(input logic lft,
                                                                 input logic rght);
    if (lft)
      return NUDGE_LFT;         // Left has priority.
    if (rght)
      return NUDGE_RGHT;
    return '0;
  endfunction

  // Returns on the falling edge after the accept edge.
  task automatic send_cmd(input opcode_e op, input logic [HFIELD_W-1:0] hf,
                          input logic [SQUARE_W-1:0] sq);
    int n0;
    n0 = accept_cnt;
    @(negedge clk);
    cmd       = {op, hf, sq};
    cmd_valid = 1'b1;
    while (accept_cnt == n0) @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic take_resp(input opcode_e op);
    while (resp_valid !== 1'b1) @(negedge clk);  // Latency varies.
    check_op("resp_op", op, resp_op);
    resp_ready = 1'b1;
    @(negedge clk);
    resp_ready = 1'b0;
    check_bit("resp_valid", 1'b0, resp_valid);
    check_bit("cmd_ready", 1'b1, cmd_ready);
  endtask

  task automatic strobe_heading();
    @(negedge clk);
    heading_rdy = 1'b1;
    @(negedge clk);
    heading_rdy = 1'b0;
  endtask

  // One clean centre line crossing, long enough for the synchroniser.
  task automatic cross_line();
    @(negedge clk);
    cntrIR = 1'b1;
    repeat (2) @(negedge clk);
    cntrIR = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic climb_speed(input int n);
    repeat (n) begin
      strobe_heading();
      if (exp_speed[SPEED_W-1 -: 2] != 2'b11)
        exp_speed = exp_speed + INC_STEP;  // Stops once top bits are ones.
      check_speed("frwrd", exp_speed, frwrd);
      check_bit("moving", 1'b1, moving);
    end
  endtask

  // Covers the squares, ramps down to rest and takes the response.
  task automatic complete_move(input opcode_e op, input int sq, input int fanfares);
    int f0;
    f0 = fanfare_cnt;
    repeat (2 * sq) cross_line();
    @(negedge clk);
    check_pulses("fanfare_go", fanfares, fanfare_cnt - f0);
    check_bit("moving", 1'b1, moving);
    while (exp_speed != '0) begin
      strobe_heading();
      exp_speed = (exp_speed < DEC_STEP) ? '0 : exp_speed - DEC_STEP;
      check_speed("frwrd", exp_speed, frwrd);
      check_bit("moving", exp_speed != '0, moving);
    end
    take_resp(op);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic calibrate_with_backpressure();
    int c0;
    int t0;
    int a0;
    c0 = cal_cnt;
    t0 = tour_cnt;
    send_cmd(CAL, 8'h00, 4'h0);
    check_pulses("strt_cal", 1, cal_cnt - c0);
    check_bit("cmd_ready", 1'b0, cmd_ready);
    repeat (3) begin
      @(negedge clk);
      check_bit("resp_valid", 1'b0, resp_valid);  // Gyro still busy.
    end
    cal_done = 1'b1;
    @(negedge clk);
    cal_done = 1'b0;
    check_bit("resp_valid", 1'b1, resp_valid);
    check_op("resp_op", CAL, resp_op);
    check_pulses("strt_cal", 1, cal_cnt - c0);
    a0        = accept_cnt;
    cmd       = {TOUR, 8'h00, 4'h0};  // Waits behind the held response.
    cmd_valid = 1'b1;
    repeat (6) begin
      @(negedge clk);
      check_bit("resp_valid", 1'b1, resp_valid);
      check_op("resp_op", CAL, resp_op);
      check_bit("cmd_ready", 1'b0, cmd_ready);
    end
    check_pulses("command accept", 0, accept_cnt - a0);
    resp_ready = 1'b1;
    @(negedge clk);
    resp_ready = 1'b0;
    check_bit("resp_valid", 1'b0, resp_valid);
    while (accept_cnt == a0) @(negedge clk);
    cmd_valid = 1'b0;
    check_pulses("tour_go", 1, tour_cnt - t0);
  endtask

  task automatic tour_handoff();
    int t0;
    t0 = tour_cnt;
    send_cmd(TOUR, 8'h00, 4'h0);
    check_pulses("tour_go", 1, tour_cnt - t0);
    check_bit("cmd_ready", 1'b1, cmd_ready);
    repeat (4) begin
      @(negedge clk);
      check_bit("resp_valid", 1'b0, resp_valid);  // Tour never answers.
    end
    check_pulses("tour_go", 1, tour_cnt - t0);
  endtask

  task automatic heading_error_rule();
    logic [HFIELD_W-1:0]         hf;
    logic [31:0]                 rnd;
    logic signed [HEADING_W-1:0] exp;
    for (int f = 0; f < 2; f++) begin
      hf = (f == 0) ? '0 : HFIELD_W'($urandom_range(255, 1));
      send_cmd(MOV, hf, 4'h0);
      for (int m = 0; m < 4; m++) begin
        for (int k = 0; k < 3; k++) begin
          rnd     = $urandom();
          @(negedge clk);
          heading = rnd[HEADING_W-1:0];
          lftIR   = (m == 1) || (m == 3);  // Mode 3 has both sensors set.
          rghtIR  = (m == 2) || (m == 3);
          repeat (2) @(negedge clk);       // Sensor synchroniser delay.
          exp = heading - desired_of(hf) + expected_nudge(lftIR, rghtIR);
          check_error("error", exp, error);
        end
      end
      lftIR   = 1'b0;
      rghtIR  = 1'b0;
      heading = desired_of(hf);            // Let the zero square move finish.
      take_resp(MOV);
    end
  endtask

  task automatic align_gate_and_ramp();
    heading = 12'sh100;                    // Far off north.
    send_cmd(MOV, 8'h00, 4'd2);
    repeat (8) begin
      strobe_heading();
      check_bit("moving", 1'b0, moving);
      check_speed("frwrd", '0, frwrd);
    end
    heading = '0;
    @(negedge clk);
    check_bit("moving", 1'b1, moving);
    check_speed("frwrd", '0, frwrd);
    exp_speed = '0;
    climb_speed(28);                       // Past the saturation point.
    check_speed("frwrd", 10'h300, frwrd);
    complete_move(MOV, 2, 0);
  endtask

  task automatic fanfare_move();
    logic signed [HEADING_W-1:0] target;
    target  = desired_of(8'h40);
    heading = target + 12'sh200;           // Misaligned once loaded.
    send_cmd(FANFARE, 8'h40, 4'd3);
    strobe_heading();
    check_bit("moving", 1'b0, moving);
    heading = target + 12'sh010;           // Inside the threshold.
    @(negedge clk);
    check_bit("moving", 1'b1, moving);
    exp_speed = '0;
    climb_speed(5);
    complete_move(FANFARE, 3, 1);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(81683));
    rst_n       = 1'b0;
    cmd         = '0;
    cmd_valid   = 1'b0;
    resp_ready  = 1'b0;
    cal_done    = 1'b0;
    heading     = '0;
    heading_rdy = 1'b0;
    lftIR       = 1'b0;
    cntrIR      = 1'b0;
    rghtIR      = 1'b0;
    exp_speed   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("cmd_ready", 1'b1, cmd_ready);
    check_bit("resp_valid", 1'b0, resp_valid);
    check_bit("strt_cal", 1'b0, strt_cal);
    check_bit("tour_go", 1'b0, tour_go);
    check_bit("fanfare_go", 1'b0, fanfare_go);
    check_bit("moving", 1'b0, moving);
    check_speed("frwrd", '0, frwrd);
    check_error("error", '0, error);       // Desired heading starts at zero.
    calibrate_with_backpressure();
    tour_handoff();
    heading_error_rule();
    align_gate_and_ramp();
    fanfare_move();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: design/cmd_proc.sv
////////////////////////////////////////////////////////////
// Command processor top level of the knight robot.
// Connects the command sequencer to the heading error,
// square counter and forward speed blocks. Gyro, PID,
// motors, link, tour engine and piezo sit outside.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cmd_proc
  import cmd_proc_pkg::*;
(
  input  logic                        clk,          // System clock.
  input  logic                        rst_n,        // Async active low reset.
  // Command channel from the wireless link.
  input  logic [CMD_W-1:0]            cmd,
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  // Response channel back to the link.
  output opcode_e                     resp_op,
  output logic                        resp_valid,
  input  logic                        resp_ready,
  // Gyro.
  output logic                        strt_cal,
  input  logic                        cal_done,
  input  logic signed [HEADING_W-1:0] heading,
  input  logic                        heading_rdy,
  // Line sensors, async.
  input  logic                        lftIR,
  input  logic                        cntrIR,
  input  logic                        rghtIR,
  // To PID, motors and other engines.
  output logic signed [HEADING_W-1:0] error,
  output logic [SPEED_W-1:0]          frwrd,
  output logic                        moving,
  output logic                        tour_go,
  output logic                        fanfare_go
);

  logic move_load;  // Move accepted.
  logic aligned;    // Heading close enough.
  logic move_done;  // Distance covered.
  logic at_rest;    // Speed at zero.
  logic ramp_clr;
  logic ramp_up;
  logic ramp_down;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////
  cmd_sequencer u_cmd_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .resp_op    (resp_op),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .strt_cal   (strt_cal),
    .cal_done   (cal_done),
    .tour_go    (tour_go),
    .fanfare_go (fanfare_go),
    .moving     (moving),
    .move_load  (move_load),
    .aligned    (aligned),
    .move_done  (move_done),
    .at_rest    (at_rest),
    .ramp_clr   (ramp_clr),
    .ramp_up    (ramp_up),
    .ramp_down  (ramp_down)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////
  heading_error u_heading_error (
    .clk           (clk),
    .rst_n         (rst_n),
    .move_load     (move_load),
    .heading_field (cmd[SQUARE_W +: HFIELD_W]),  // cmd[11:4].
    .heading       (heading),
    .lftIR         (lftIR),
    .rghtIR        (rghtIR),
    .error         (error),
    .aligned       (aligned)
  );

  square_counter u_square_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .move_load (move_load),
    .squares   (cmd[SQUARE_W-1:0]),              // cmd[3:0].
    .cntrIR    (cntrIR),
    .move_done (move_done)
  );

  speed_ramp u_speed_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .ramp_clr    (ramp_clr),
    .ramp_up     (ramp_up),
    .ramp_down   (ramp_down),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .at_rest     (at_rest)
  );

endmodule

// File: design/cmd_sequencer.sv
////////////////////////////////////////////////////////////
// Command sequencer.
// Accepts commands on a valid/ready channel, starts the
// gyro calibration or the tour engine, steps a move from
// alignment through ramp up and ramp down, and returns a
// held response on a valid/ready channel.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cmd_sequencer
  import cmd_proc_pkg::*;
(
  input  logic             clk,         // System clock.
  input  logic             rst_n,       // Async active low reset.
  // Command channel.
  input  logic [CMD_W-1:0] cmd,         // Command word.
  input  logic             cmd_valid,   // Source has a command.
  output logic             cmd_ready,   // Idle and able to take it.
  // Response channel.
  output opcode_e          resp_op,     // Opcode being answered.
  output logic             resp_valid,  // Response pending.
  input  logic             resp_ready,  // Sink takes the response.
  // External engines.
  output logic             strt_cal,    // Kick gyro calibration.
  input  logic             cal_done,    // Gyro finished.
  output logic             tour_go,     // Kick tour engine.
  output logic             fanfare_go,  // Kick the piezo tune.
  output logic             moving,      // Robot under way.
  // Datapath control.
  output logic             move_load,   // Load move fields.
  input  logic             aligned,     // Heading error small.
  input  logic             move_done,   // Squares covered.
  input  logic             at_rest,     // Speed is zero.
  output logic             ramp_clr,    // Zero the speed.
  output logic             ramp_up,     // Accelerate.
  output logic             ramp_down    // Decelerate.
);

  typedef enum logic [2:0] {
    IDLE,
    CALIBRATE,
    ALIGN,
    RAMP_UP,
    RAMP_DOWN,
    RESPOND
  } state_e;

  state_e  state;       // Current state.
  state_e  nxt_state;   // Next state.
  opcode_e cmd_op;      // Opcode of the incoming word.
  opcode_e op_q;        // Opcode of the command in flight.
  logic    accept;      // Command transfer this cycle.

  assign cmd_op    = opcode_e'(cmd[CMD_W-1 -: 4]);
  assign cmd_ready = (state == IDLE);          // Busy or answering blocks new work.
  assign accept    = cmd_valid & cmd_ready;

  assign resp_valid = (state == RESPOND);      // Held until the sink takes it.
  assign resp_op    = op_q;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  // Kept for the response and the fanfare decision.
  always_ff @(posedge clk) begin
    if (accept)
      op_q <= cmd_op;
  end

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state  = state;   // Hold by default.
    strt_cal   = 1'b0;
    tour_go    = 1'b0;
    fanfare_go = 1'b0;
    moving     = 1'b0;
    move_load  = 1'b0;
    ramp_clr   = 1'b0;
    ramp_up    = 1'b0;
    ramp_down  = 1'b0;

    case (state)
      IDLE: begin
        if (accept) begin
          case (cmd_op)
            TOUR: begin
              tour_go = 1'b1;           // Fire and forget, no response.
            end
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            default: begin              // Any other opcode is a move.
              move_load = 1'b1;
              nxt_state = ALIGN;
            end
          endcase
        end
      end

      CALIBRATE: begin
        if (cal_done)
          nxt_state = RESPOND;
      end

      ALIGN: begin
        if (aligned) begin              // Turned far enough, start from zero.
          ramp_clr  = 1'b1;
          nxt_state = RAMP_UP;
        end
      end

      RAMP_UP: begin
        moving = 1'b1;
        if (move_done) begin
          ramp_down  = 1'b1;
          fanfare_go = (op_q == FANFARE);  // Only the fanfare move plays.
          nxt_state  = RAMP_DOWN;
        end else begin
          ramp_up = 1'b1;
        end
      end

      RAMP_DOWN: begin
        ramp_down = 1'b1;
        moving    = ~at_rest;
        if (at_rest)
          nxt_state = RESPOND;
      end

      RESPOND: begin
        if (resp_ready)
          nxt_state = IDLE;
      end

      default: begin
        nxt_state = IDLE;
      end
    endcase
  end

endmodule

// File: design/speed_ramp.sv
////////////////////////////////////////////////////////////
// Forward speed register.
// Steps up or down once per heading sample under control
// of the sequencer; saturates near full speed going up
// and floors at zero going down.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module speed_ramp
  import cmd_proc_pkg::*;
(
  input  logic               clk,          // System clock.
  input  logic               rst_n,        // Async active low reset.
  input  logic               ramp_clr,     // Zero the speed.
  input  logic               ramp_up,      // Accelerate on samples.
  input  logic               ramp_down,    // Decelerate on samples.
  input  logic               heading_rdy,  // New gyro sample strobe.
  output logic [SPEED_W-1:0] frwrd,        // Forward speed to motors.
  output logic               at_rest       // Speed is zero.
);

  logic at_max;  // Top two bits set.

  assign at_max  = &frwrd[SPEED_W-1 -: 2];
  assign at_rest = (frwrd == '0);

  ////////////////////////////////////////////////////////////
  // Speed register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (ramp_clr) begin
      frwrd <= '0;                          // Start every move from standstill.
    end else if (heading_rdy) begin         // Only move on a fresh sample.
      if (ramp_up) begin
        if (!at_max)
          frwrd <= frwrd + INC_STEP;
      end else if (ramp_down) begin
        if (frwrd < DEC_STEP)
          frwrd <= '0;                      // Last step lands on zero.
        else
          frwrd <= frwrd - DEC_STEP;
      end
    end
  end

endmodule

// File: design/square_counter.sv
////////////////////////////////////////////////////////////
// Square counter for straight moves.
// Synchronises the centre line sensor, counts its rising
// edges and raises move_done once two crossings per
// requested square have been seen.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module square_counter
  import cmd_proc_pkg::*;
(
  input  logic                clk,        // System clock.
  input  logic                rst_n,      // Async active low reset.
  input  logic                move_load,  // Start of a move.
  input  logic [SQUARE_W-1:0] squares,    // Squares requested.
  input  logic                cntrIR,     // Centre line sensor, async.
  output logic                move_done   // Requested distance covered.
);

  logic                cntr_meta;   // First sync stage.
  logic                cntr_sync;   // Settled sensor.
  logic                cntr_prev;   // Delayed copy for edge detect.
  logic                cntr_rise;   // One cycle per line crossing.
  logic [SQUARE_W-1:0] squares_q;   // Latched square count.
  logic [SQUARE_W:0]   cross_cnt;   // Crossings so far, two per square.

  ////////////////////////////////////////////////////////////
  // Sensor sync and edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_meta <= 1'b0;
      cntr_sync <= 1'b0;
      cntr_prev <= 1'b0;
    end else begin
      cntr_meta <= cntrIR;
      cntr_sync <= cntr_meta;
      cntr_prev <= cntr_sync;  // Edge reference.
    end
  end

  assign cntr_rise = cntr_sync & ~cntr_prev;  // Low to high on the settled line.

  ////////////////////////////////////////////////////////////
  // Crossing count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      squares_q <= '0;
      cross_cnt <= '0;
    end else if (move_load) begin
      squares_q <= squares;     // Distance of this move.
      cross_cnt <= '0;          // Fresh count.
    end else if (cntr_rise) begin
      cross_cnt <= cross_cnt + 1'b1;
    end
  end

  // Each square has a line at both edges of the centre mark.
  assign move_done = (cross_cnt == {squares_q, 1'b0});

endmodule

// File: design/heading_error.sv
////////////////////////////////////////////////////////////
// Heading error for the external PID.
// Latches the desired heading at move start, synchronises
// the side line sensors into a nudge and flags when the
// robot points close enough to start driving.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module heading_error
  import cmd_proc_pkg::*;
(
  input  logic                        clk,            // System clock.
  input  logic                        rst_n,          // Async active low reset.
  input  logic                        move_load,      // Start of a move.
  input  logic [HFIELD_W-1:0]         heading_field,  // Heading bits of the command.
  input  logic signed [HEADING_W-1:0] heading,        // Gyro heading.
  input  logic                        lftIR,          // Left line sensor, async.
  input  logic                        rghtIR,         // Right line sensor, async.
  output logic signed [HEADING_W-1:0] error,          // To PID.
  output logic                        aligned         // Error inside threshold.
);

  logic                        lft_meta;      // First sync stage.
  logic                        lft_sync;      // Usable left sensor.
  logic                        rght_meta;     // First sync stage.
  logic                        rght_sync;     // Usable right sensor.
  logic signed [HEADING_W-1:0] desired_hdg;   // Target heading of the move.
  logic signed [HEADING_W-1:0] nudge;         // Sensor correction term.
  logic        [HEADING_W-1:0] err_mag;       // |error|.

  ////////////////////////////////////////////////////////////
  // Side sensor synchronisers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lft_meta  <= 1'b0;
      lft_sync  <= 1'b0;
      rght_meta <= 1'b0;
      rght_sync <= 1'b0;
    end else begin
      lft_meta  <= lftIR;      // May go metastable.
      lft_sync  <= lft_meta;   // Settled copy.
      rght_meta <= rghtIR;
      rght_sync <= rght_meta;
    end
  end

  // Left wins if both sensors see the line.
  assign nudge = lft_sync  ? NUDGE_LFT  :
                 rght_sync ? NUDGE_RGHT :
                 '0;

  ////////////////////////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////////////////////////
  // A zero field means north; otherwise pad the low nibble with ones.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_hdg <= '0;
    end else if (move_load) begin
      if (heading_field == '0)
        desired_hdg <= '0;
      else
        desired_hdg <= {heading_field, {(HEADING_W-HFIELD_W){1'b1}}};
    end
  end

  ////////////////////////////////////////////////////////////
  // Error and alignment
  ////////////////////////////////////////////////////////////
  assign error = heading - desired_hdg + nudge;  // Wraps at 12 bits.

  assign err_mag = error[HEADING_W-1] ? -error : error;  // Two's complement abs.

  assign aligned = (err_mag < ALIGN_THR);  // Close enough to drive.

endmodule

// File: design/cmd_proc_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the knight command processor.
// Holds the command opcodes, the field and datapath widths
// and the fixed motion constants used by every block.
// Import with a wildcard in the module header.
////////////////////////////////////////////////////////////
package cmd_proc_pkg;

  ////////////////////////////////////////////////////////////
  // Command word layout
  ////////////////////////////////////////////////////////////
  localparam int CMD_W     = 16;  // Full command word.
  localparam int HFIELD_W  = 8;   // Heading field, cmd[11:4].
  localparam int SQUARE_W  = 4;   // Square count, cmd[3:0].

  // Opcode sits in the top nibble of the command word.
  typedef enum logic [3:0] {
    CAL     = 4'h2,  // Gyro calibration.
    MOV     = 4'h4,  // Plain straight move.
    FANFARE = 4'h5,  // Move, then play the charge tune.
    TOUR    = 4'h6   // Hand off to the tour engine.
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////
  localparam int HEADING_W = 12;  // Heading and error, signed.
  localparam int SPEED_W   = 10;  // Forward speed register.

  ////////////////////////////////////////////////////////////
  // Motion constants
  ////////////////////////////////////////////////////////////
  // Speed steps, applied once per heading sample.
  localparam logic [SPEED_W-1:0] INC_STEP = 10'h020;  // Ramp up.
  localparam logic [SPEED_W-1:0] DEC_STEP = 10'h040;  // Ramp down.

  // Line sensor nudges pull the robot back onto the line.
  localparam logic signed [HEADING_W-1:0] NUDGE_LFT  = 12'h1FF;  // Positive.
  localparam logic signed [HEADING_W-1:0] NUDGE_RGHT = 12'hE00;  // Negative.

  // Error magnitude under this counts as pointing the right way.
  localparam logic [HEADING_W-1:0] ALIGN_THR = 12'h02C;

endpackage
